// File: riscvPipeline.f
+incdir+include
src/riscvPkg.sv
src/instructionFetch.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/riscvPipeline.sv
bench/retireChecker.sv
bench/riscvPipelineTb.sv

// File: bench/riscvPipeline_golden.txt
// @00 program: word count, then instruction words in hex, four per line
// @40 writes: write count, then one line per write with register and value in hex
@00
34
00500093 FFD08113 002081B3 40300233  // addi, addi, add, sub with forwarding
001222B3 00123333 FFA22393 FFF0B413  // slt, sltu, slti, sltiu on a negative operand
00419493 01C25513 023205B3 12345637  // slli, srli, mul, lui
00001697 67860713 00E02423 00802783  // auipc, addi, sw, lw
00178833 00108863 00100A13 00200A93  // load use, taken beq and its shadow
00300B13 00209863 00100A13 00200A93  // taken bne
00300B13 00124863 00100A13 00200A93  // taken blt
00300B13 0040D863 00100A13 00200A93  // taken bge
00300B13 00208863 0040C863 01100893  // beq and blt not taken, addi
0100096F 00100A13 00200A93 00300B13  // jal x18
0B400993 00098BE7 00100A13 00200A93  // addi x19, jalr x23
00300B13 0080006F 00100A13 012B8C33  // jal x0, add x24
0000006F 00000013 00000013 00000013  // self loop and padding
@40
15
01 00000005
02 00000002
03 00000007
04 FFFFFFF9
05 00000001
06 00000000
07 00000001
08 00000001
09 00000070
0A 0000000F
0B FFFFFFCF
0C 12345000
0D 00001030
0E 12345678
0F 12345678
10 1234567D
11 00000011
12 00000094
13 000000B4
17 000000A8
18 0000013C

// File: bench/riscvPipelineTb.sv
`timescale 1ns/1ns

module riscvPipelineTb;

  localparam int clockPeriod = 8;
  localparam int runTimeout  = 10000;   // Cycles for the whole program plus quiet window

  logic                 clock;
  logic                 reset;
  logic                 run;
  logic                 progWrite;
  riscvPkg::imemIndex_t progAddress;
  riscvPkg::word_t      progData;
  logic                 retireValid;
  riscvPkg::regIndex_t  retireRd;
  riscvPkg::word_t      retireData;

  // Results from the checker
  logic checkDone;
  int   writesSeen;
  int   mismatchCount;
  int   otherCount;

  riscvPkg::word_t golden [0:255];
  int              programLength;
  int              wordIndex;
  int              cycles;

  riscvPipeline dut (
    .clock       (clock),
    .reset       (reset),
    .run         (run),
    .progWrite   (progWrite),
    .progAddress (progAddress),
    .progData    (progData),
    .retireValid (retireValid),
    .retireRd    (retireRd),
    .retireData  (retireData)
  );

  retireChecker retireCheck (
    .clock         (clock),
    .retireValid   (retireValid),
    .retireRd      (retireRd),
    .retireData    (retireData),
    .writesSeen    (writesSeen),
    .mismatchCount (mismatchCount),
    .otherCount    (otherCount),
    .done          (checkDone)
  );

  initial begin
    clock = 1'b0;
    forever #(clockPeriod / 2) clock = ~clock;
  end

  // One instruction word per cycle through the load port
  task automatic loadProgram();
    for (wordIndex = 0; wordIndex < programLength; wordIndex++) begin
      @(posedge clock);
      progWrite   <= 1'b1;
      progAddress <= riscvPkg::imemIndex_t'(wordIndex);
      progData    <= golden[1 + wordIndex];   // Words follow the length entry
    end
    @(posedge clock);
    progWrite <= 1'b0;
  endtask

  // ==================================================
  // Reset, program load and run
  // ==================================================
  initial begin
    reset       = 1'b1;
    run         = 1'b0;
    progWrite   = 1'b0;
    progAddress = '0;
    progData    = '0;
    $readmemh("bench/riscvPipeline_golden.txt", golden);
    programLength = golden[0];

    repeat (2) @(posedge clock);
    reset <= 1'b0;

    loadProgram();
    run <= 1'b1;   // PC leaves the reset vector from here

    cycles = 0;
    while (checkDone !== 1'b1 && cycles < runTimeout) begin
      @(posedge clock);
      cycles++;
    end

    if (checkDone !== 1'b1)
      $display("Timed out after %0d cycles waiting for the retirement checker", cycles);
    $display("Checked %0d writes: %0d mismatches, %0d other errors",
             writesSeen, mismatchCount, otherCount);
    if (checkDone === 1'b1 && mismatchCount == 0 && otherCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: bench/retireChecker.sv
`timescale 1ns/1ns

module retireChecker (
  input  logic                clock,
  input  logic                retireValid,
  input  riscvPkg::regIndex_t retireRd,
  input  riscvPkg::word_t     retireData,
  output int                  writesSeen,
  output int                  mismatchCount,
  output int                  otherCount,
  output logic                done
);

  localparam int writeBase    = 'h40;  // Write section of the golden file
  localparam int writeTimeout = 400;   // Also covers program loading before the first write
  localparam int quietCycles  = 100;

  riscvPkg::word_t     golden [0:255];
  riscvPkg::regIndex_t expectRd;
  riscvPkg::word_t     expectData;
  int                  expectCount;
  int                  waited;
  logic                found;
  logic                stalled;

  initial begin
    writesSeen    = 0;
    mismatchCount = 0;
    otherCount    = 0;
    done          = 1'b0;
    stalled       = 1'b0;
    $readmemh("bench/riscvPipeline_golden.txt", golden);
    expectCount = golden[writeBase];

    if (expectCount <= 0) begin
      $display("The golden file lists no expected register writes");
      otherCount++;
      stalled = 1'b1;
    end

    // ==================================================
    // Expected writes, in retirement order
    // ==================================================
    while (writesSeen < expectCount && !stalled) begin
      expectRd   = golden[writeBase + 1 + 2 * writesSeen][4:0];
      expectData = golden[writeBase + 2 + 2 * writesSeen];
      found      = 1'b0;
      waited     = 0;
      while (!found && waited < writeTimeout) begin
        @(negedge clock);   // Retire port settled since the rising edge
        waited++;
        found = (retireValid === 1'b1);
      end
      if (found) begin
        if (retireRd !== expectRd) begin
          $display("FAILED retireRd at write %0d: expected %h, got %h",
                   writesSeen, expectRd, retireRd);
          mismatchCount++;
        end
        if (retireData !== expectData) begin
          $display("FAILED retireData at write %0d (x%0d): expected %h, got %h",
                   writesSeen, expectRd, expectData, retireData);
          mismatchCount++;
        end
        writesSeen++;
      end else begin
        $display("No retirement within %0d cycles while waiting for write %0d",
                 writeTimeout, writesSeen);
        otherCount++;
        stalled = 1'b1;
      end
    end

    // Self loop at the end writes x0 only
    if (!stalled) begin
      for (waited = 0; waited < quietCycles; waited++) begin
        @(negedge clock);
        if (retireValid !== 1'b0) begin
          $display("Unexpected retirement after the last write, x%0d with value %h",
                   retireRd, retireData);
          otherCount++;
        end
      end
    end
    done = 1'b1;
  end

endmodule

// File: src/riscvPipeline.sv
`timescale 1ns/1ns

module riscvPipeline (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 run,
  input  logic                 progWrite,
  input  riscvPkg::imemIndex_t progAddress,
  input  riscvPkg::word_t      progData,
  output logic                 retireValid,
  output riscvPkg::regIndex_t  retireRd,
  output riscvPkg::word_t      retireData
);

  // IF to ID
  riscvPkg::word_t     fetchInstr, fetchPc;
  logic                loadUseStall;

  // ID to EX
  riscvPkg::aluOp_t    exAluOp;
  riscvPkg::word_t     exPc, exImm, exRs1Value, exRs2Value;
  riscvPkg::regIndex_t exRs1, exRs2, exRd;
  logic                exUsePc, exUseImm, exRegWrite, exMemRead, exMemWrite;
  logic                exBranch, exJal, exJalr, exBranchOnSign, exBranchInvert;

  // EX to MEM and redirect
  logic                redirect;
  riscvPkg::word_t     redirectTarget;
  riscvPkg::word_t     memAluResult, memStoreData, memLinkValue;
  riscvPkg::regIndex_t memRd;
  logic                memRegWrite, memMemRead, memMemWrite;

  // Writeback, fed to the register file and to forwarding
  logic                wbWrite;
  riscvPkg::regIndex_t wbRd;
  riscvPkg::word_t     wbData;

  instructionFetch fetch (.*);

  decodeStage decode (.*);

  executeStage execute (.*);

  memoryStage memory (.*);

  // Each register write is reported as it retires
  assign retireValid = wbWrite;
  assign retireRd    = wbRd;
  assign retireData  = wbData;

endmodule

// File: src/memoryStage.sv
`timescale 1ns/1ns
`include "riscv_consts.svh"

module memoryStage (
  input  logic                clock,
  input  logic                reset,
  input  riscvPkg::word_t     memAluResult,
  input  riscvPkg::word_t     memStoreData,
  input  riscvPkg::word_t     memLinkValue,
  input  riscvPkg::regIndex_t memRd,
  input  logic                memRegWrite,
  input  logic                memMemRead,
  input  logic                memMemWrite,
  output logic                wbWrite,
  output riscvPkg::regIndex_t wbRd,
  output riscvPkg::word_t     wbData
);

  riscvPkg::word_t dmem [`RISCV_DMEM_WORDS];
  logic [$clog2(`RISCV_DMEM_WORDS)-1:0] dataIndex;

  // MEM/WB payload
  riscvPkg::word_t wbLoadData;
  riscvPkg::word_t wbResult;
  logic            wbFromMem;

  assign dataIndex = memAluResult[$clog2(`RISCV_DMEM_WORDS)+1:2];  // Word address

  // ==================================================
  // Data memory and MEM/WB register
  // ==================================================
  always_ff @(posedge clock) begin
    if (memMemWrite)
      dmem[dataIndex] <= memStoreData;
    wbLoadData <= dmem[dataIndex];
    wbResult   <= memLinkValue;
    wbFromMem  <= memMemRead;
    wbRd       <= memRd;
  end

  // Writes to x0 are dropped here
  always_ff @(posedge clock or posedge reset) begin
    if (reset)
      wbWrite <= 1'b0;
    else
      wbWrite <= memRegWrite && memRd != '0;
  end

  assign wbData = wbFromMem ? wbLoadData : wbResult;

endmodule

// File: src/executeStage.sv
`timescale 1ns/1ns
`include "riscv_consts.svh"

module executeStage (
  input  logic                clock,
  input  logic                reset,
  input  riscvPkg::aluOp_t    exAluOp,
  input  riscvPkg::word_t     exPc,
  input  riscvPkg::word_t     exImm,
  input  riscvPkg::word_t     exRs1Value,
  input  riscvPkg::word_t     exRs2Value,
  input  riscvPkg::regIndex_t exRs1,
  input  riscvPkg::regIndex_t exRs2,
  input  riscvPkg::regIndex_t exRd,
  input  logic                exUsePc,
  input  logic                exUseImm,
  input  logic                exRegWrite,
  input  logic                exMemRead,
  input  logic                exMemWrite,
  input  logic                exBranch,
  input  logic                exJal,
  input  logic                exJalr,
  input  logic                exBranchOnSign,
  input  logic                exBranchInvert,
  input  logic                wbWrite,
  input  riscvPkg::regIndex_t wbRd,
  input  riscvPkg::word_t     wbData,
  output logic                redirect,
  output riscvPkg::word_t     redirectTarget,
  output riscvPkg::word_t     memAluResult,
  output riscvPkg::word_t     memStoreData,
  output riscvPkg::word_t     memLinkValue,
  output riscvPkg::regIndex_t memRd,
  output logic                memRegWrite,
  output logic                memMemRead,
  output logic                memMemWrite
);

  riscvPkg::word_t rs1Fwd, rs2Fwd;
  riscvPkg::word_t operandA, operandB;
  riscvPkg::word_t aluResult;
  logic            flagZero, flagNegative;

  // EX/MEM fields kept local to this stage
  logic            memBranch, memJal, memJalr, memBranchOnSign, memBranchInvert;
  logic            memZero, memNegative;
  riscvPkg::word_t memTarget, memPcStep;

  // ==================================================
  // Forwarding and operand select
  // ==================================================
  // EX/MEM first, except loads whose data is still in memory
  always_comb begin
    rs1Fwd = exRs1Value;
    if (memRegWrite && !memMemRead && memRd != '0 && memRd == exRs1)
      rs1Fwd = memLinkValue;
    else if (wbWrite && wbRd == exRs1)
      rs1Fwd = wbData;
    rs2Fwd = exRs2Value;
    if (memRegWrite && !memMemRead && memRd != '0 && memRd == exRs2)
      rs2Fwd = memLinkValue;
    else if (wbWrite && wbRd == exRs2)
      rs2Fwd = wbData;
  end

  assign operandA = exUsePc  ? exPc  : rs1Fwd;
  assign operandB = exUseImm ? exImm : rs2Fwd;

  // ==================================================
  // ALU
  // ==================================================
  always_comb begin
    case (exAluOp)
      riscvPkg::aluAdd:  aluResult = operandA + operandB;
      riscvPkg::aluSub:  aluResult = operandA - operandB;
      riscvPkg::aluSrl:  aluResult = operandA >> operandB[4:0];
      riscvPkg::aluSll:  aluResult = operandA << operandB[4:0];
      riscvPkg::aluSlt:  aluResult = {31'b0, $signed(operandA) < $signed(operandB)};
      riscvPkg::aluSltu: aluResult = {31'b0, operandA < operandB};
      riscvPkg::aluMul:  aluResult = operandA * operandB;   // Low 32 bits
      default:           aluResult = '0;
    endcase
  end

  assign flagZero     = (aluResult == '0);
  assign flagNegative = $signed(operandA) < $signed(operandB);  // True signed less-than

  // ==================================================
  // EX/MEM register
  // ==================================================
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      {memRegWrite, memMemRead, memMemWrite, memBranch, memJal, memJalr} <= '0;
    end else if (redirect) begin
      {memRegWrite, memMemRead, memMemWrite, memBranch, memJal, memJalr} <= '0;
    end else begin
      memRegWrite <= exRegWrite;
      memMemRead  <= exMemRead;
      memMemWrite <= exMemWrite;
      memBranch   <= exBranch;
      memJal      <= exJal;
      memJalr     <= exJalr;
    end
  end

  always_ff @(posedge clock) begin
    memAluResult    <= aluResult;
    memStoreData    <= rs2Fwd;
    memRd           <= exRd;
    memBranchOnSign <= exBranchOnSign;
    memBranchInvert <= exBranchInvert;
    memZero         <= flagZero;
    memNegative     <= flagNegative;
    memTarget       <= exPc + exImm;
    memPcStep       <= exPc + `RISCV_PC_STEP;
  end

  // Branch resolution out of EX/MEM
  assign redirect = (memBranch && ((memBranchOnSign ? memNegative : memZero) ^ memBranchInvert))
                    || memJal || memJalr;

  assign redirectTarget = memJalr ? {memAluResult[31:1], 1'b0} : memTarget;

  assign memLinkValue = (memJal || memJalr) ? memPcStep : memAluResult;  // Jumps link PC+4

endmodule

// File: src/decodeStage.sv
`timescale 1ns/1ns
`include "riscv_consts.svh"

module decodeStage (
  input  logic                clock,
  input  logic                reset,
  input  riscvPkg::word_t     fetchInstr,
  input  riscvPkg::word_t     fetchPc,
  input  logic                redirect,
  input  logic                wbWrite,
  input  riscvPkg::regIndex_t wbRd,
  input  riscvPkg::word_t     wbData,
  output logic                loadUseStall,
  output riscvPkg::aluOp_t    exAluOp,
  output riscvPkg::word_t     exPc,
  output riscvPkg::word_t     exImm,
  output riscvPkg::word_t     exRs1Value,
  output riscvPkg::word_t     exRs2Value,
  output riscvPkg::regIndex_t exRs1,
  output riscvPkg::regIndex_t exRs2,
  output riscvPkg::regIndex_t exRd,
  output logic                exUsePc,
  output logic                exUseImm,
  output logic                exRegWrite,
  output logic                exMemRead,
  output logic                exMemWrite,
  output logic                exBranch,
  output logic                exJal,
  output logic                exJalr,
  output logic                exBranchOnSign,
  output logic                exBranchInvert
);

  riscvPkg::word_t     regFile [`RISCV_REG_COUNT];
  riscvPkg::opcode_t   opcode;
  riscvPkg::regIndex_t rs1;
  riscvPkg::regIndex_t rs2;
  riscvPkg::regIndex_t rd;
  riscvPkg::word_t     rs1Value;
  riscvPkg::word_t     rs2Value;
  logic [2:0]          funct3;
  logic [6:0]          funct7;

  // Decoded controls
  riscvPkg::aluOp_t aluOp;
  riscvPkg::word_t  imm;
  logic usePc, useImm, regWrite, memRead, memWrite;
  logic branch, jal, jalr, branchOnSign, branchInvert;

  assign opcode = riscvPkg::opcode_t'(fetchInstr[6:0]);
  assign funct3 = fetchInstr[14:12];
  assign funct7 = fetchInstr[31:25];
  assign rd     = fetchInstr[11:7];
  assign rs2    = fetchInstr[24:20];
  // LUI keeps immediate bits in the rs1 field so it reads x0 instead
  assign rs1    = (opcode == riscvPkg::opLui) ? '0 : fetchInstr[19:15];

  // ==================================================
  // Controller and immediate generation
  // ==================================================
  always_comb begin
    aluOp        = riscvPkg::aluAdd;
    imm          = '0;
    usePc        = 1'b0;   // Operand A is rs1 unless set
    useImm       = 1'b0;   // Operand B is rs2 unless set
    regWrite     = 1'b0;
    memRead      = 1'b0;
    memWrite     = 1'b0;
    branch       = 1'b0;
    jal          = 1'b0;
    jalr         = 1'b0;
    branchOnSign = 1'b0;   // Zero flag by default
    branchInvert = 1'b0;
    case (opcode)
      riscvPkg::opImm: begin
        regWrite = 1'b1;
        useImm   = 1'b1;
        imm      = {{20{fetchInstr[31]}}, fetchInstr[31:20]};
        case (funct3)
          3'b001:  aluOp = riscvPkg::aluSll;
          3'b010:  aluOp = riscvPkg::aluSlt;
          3'b011:  aluOp = riscvPkg::aluSltu;
          3'b101:  aluOp = riscvPkg::aluSrl;
          default: aluOp = riscvPkg::aluAdd;
        endcase
      end
      riscvPkg::opLoad: begin
        regWrite = 1'b1;
        memRead  = 1'b1;
        useImm   = 1'b1;
        imm      = {{20{fetchInstr[31]}}, fetchInstr[31:20]};
      end
      riscvPkg::opStore: begin
        memWrite = 1'b1;
        useImm   = 1'b1;
        imm      = {{20{fetchInstr[31]}}, fetchInstr[31:25], fetchInstr[11:7]};
      end
      riscvPkg::opReg: begin
        regWrite = 1'b1;
        if (funct7 == 7'b0100000 && funct3 == 3'b000)
          aluOp = riscvPkg::aluSub;
        else if (funct7 == 7'b0000001 && funct3 == 3'b000)
          aluOp = riscvPkg::aluMul;
        else if (funct7 == 7'b0000000 && funct3 == 3'b010)
          aluOp = riscvPkg::aluSlt;
        else if (funct7 == 7'b0000000 && funct3 == 3'b011)
          aluOp = riscvPkg::aluSltu;
      end
      riscvPkg::opBranch: begin
        branch       = 1'b1;
        aluOp        = riscvPkg::aluSub;                  // Compare via rs1 - rs2
        imm          = {{20{fetchInstr[31]}}, fetchInstr[7], fetchInstr[30:25],
                        fetchInstr[11:8], 1'b0};
        branchOnSign = funct3[2];                         // BLT and BGE
        branchInvert = funct3[0];                         // BNE and BGE
      end
      riscvPkg::opJal: begin
        regWrite = 1'b1;
        jal      = 1'b1;
        usePc    = 1'b1;
        useImm   = 1'b1;
        imm      = {{12{fetchInstr[31]}}, fetchInstr[19:12], fetchInstr[20],
                    fetchInstr[30:21], 1'b0};
      end
      riscvPkg::opJalr: begin
        regWrite = 1'b1;
        jalr     = 1'b1;
        useImm   = 1'b1;
        imm      = {{20{fetchInstr[31]}}, fetchInstr[31:20]};
      end
      riscvPkg::opAuipc: begin
        regWrite = 1'b1;
        usePc    = 1'b1;
        useImm   = 1'b1;
        imm      = {fetchInstr[31:12], 12'b0};
      end
      riscvPkg::opLui: begin
        regWrite = 1'b1;
        useImm   = 1'b1;                                  // x0 + upper immediate
        imm      = {fetchInstr[31:12], 12'b0};
      end
      default: begin
      end
    endcase
  end

  // ==================================================
  // Register file
  // ==================================================
  always_ff @(posedge clock) begin
    if (wbWrite)
      regFile[wbRd] <= wbData;
  end

  // Same-cycle writeback is bypassed into the read
  assign rs1Value = (rs1 == '0) ? '0 : (wbWrite && wbRd == rs1) ? wbData : regFile[rs1];
  assign rs2Value = (rs2 == '0) ? '0 : (wbWrite && wbRd == rs2) ? wbData : regFile[rs2];

  // Load result is not ready until MEM/WB
  assign loadUseStall = exMemRead && exRd != '0 && (exRd == rs1 || exRd == rs2);

  // ==================================================
  // ID/EX register
  // ==================================================
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      {exRegWrite, exMemRead, exMemWrite, exBranch, exJal, exJalr} <= '0;
    end else if (redirect || loadUseStall) begin
      {exRegWrite, exMemRead, exMemWrite, exBranch, exJal, exJalr} <= '0;  // Bubble
    end else begin
      exRegWrite <= regWrite;
      exMemRead  <= memRead;
      exMemWrite <= memWrite;
      exBranch   <= branch;
      exJal      <= jal;
      exJalr     <= jalr;
    end
  end

  always_ff @(posedge clock) begin
    exAluOp        <= aluOp;
    exPc           <= fetchPc;
    exImm          <= imm;
    exRs1Value     <= rs1Value;
    exRs2Value     <= rs2Value;
    exRs1          <= rs1;
    exRs2          <= rs2;
    exRd           <= rd;
    exUsePc        <= usePc;
    exUseImm       <= useImm;
    exBranchOnSign <= branchOnSign;
    exBranchInvert <= branchInvert;
  end

endmodule

// File: src/instructionFetch.sv
`timescale 1ns/1ns
`include "riscv_consts.svh"

module instructionFetch (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 run,
  input  logic                 progWrite,
  input  riscvPkg::imemIndex_t progAddress,
  input  riscvPkg::word_t      progData,
  input  logic                 loadUseStall,
  input  logic                 redirect,
  input  riscvPkg::word_t      redirectTarget,
  output riscvPkg::word_t      fetchInstr,
  output riscvPkg::word_t      fetchPc
);

  riscvPkg::word_t      pc;
  riscvPkg::word_t      imem [`RISCV_IMEM_WORDS];
  riscvPkg::imemIndex_t fetchIndex;

  assign fetchIndex = pc[`RISCV_IMEM_INDEX_BITS+1:2];  // Drop byte offset

  // Program load port, only used while idle
  always_ff @(posedge clock) begin
    if (progWrite)
      imem[progAddress] <= progData;
  end

  // ==================================================
  // Program counter
  // ==================================================
  always_ff @(posedge clock or posedge reset) begin
    if (reset)
      pc <= '0;
    else if (!run)
      pc <= '0;                          // Parked at the reset vector
    else if (redirect)
      pc <= redirectTarget;              // Taken branch or jump wins over a stall
    else if (!loadUseStall)
      pc <= pc + `RISCV_PC_STEP;
  end

  // ==================================================
  // IF/ID register
  // ==================================================
  // An all-zero word has no valid opcode and decodes as a bubble
  always_ff @(posedge clock or posedge reset) begin
    if (reset)
      fetchInstr <= '0;
    else if (!run || redirect)
      fetchInstr <= '0;
    else if (!loadUseStall)
      fetchInstr <= imem[fetchIndex];
  end

  always_ff @(posedge clock) begin
    if (!loadUseStall)
      fetchPc <= pc;
  end

endmodule

// File: src/riscvPkg.sv
package riscvPkg;

`include "riscv_consts.svh"

  typedef logic [`RISCV_XLEN-1:0] word_t;                    // Data word or byte address
  typedef logic [$clog2(`RISCV_REG_COUNT)-1:0] regIndex_t;   // x0..x31
  typedef logic [`RISCV_IMEM_INDEX_BITS-1:0] imemIndex_t;    // Word index into IMEM

  // ALU operation select
  typedef enum logic [3:0] {
    aluAdd  = 4'd1,
    aluSub  = 4'd2,
    aluSrl  = 4'd3,
    aluSll  = 4'd4,
    aluSlt  = 4'd5,
    aluSltu = 4'd6,
    aluMul  = 4'd8
  } aluOp_t;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    opImm    = 7'b0010011,
    opLoad   = 7'b0000011,
    opStore  = 7'b0100011,
    opReg    = 7'b0110011,
    opBranch = 7'b1100011,
    opJal    = 7'b1101111,
    opJalr   = 7'b1100111,
    opAuipc  = 7'b0010111,
    opLui    = 7'b0110111
  } opcode_t;

endpackage

// File: include/riscv_consts.svh
`ifndef RISCV_CONSTS_SVH
`define RISCV_CONSTS_SVH

// ==================================================
// Datapath widths
// ==================================================

`define RISCV_XLEN 32

// Architectural integer registers, x0 included
`define RISCV_REG_COUNT 32

// ==================================================
// Memory sizes
// ==================================================

// Instruction memory, one word per entry
`define RISCV_IMEM_WORDS 1024
`define RISCV_IMEM_INDEX_BITS 10

// Data memory, word addressed through byte address bits 11..2
`define RISCV_DMEM_WORDS 1024

// ==================================================
// Sequential fetch
// ==================================================

`define RISCV_PC_STEP 4

`endif
